//--- all.f
src/core_pkg.sv
src/xgmii_rx_parser.sv
src/frame_fifo.sv
src/xgmii_tx_framer.sv
src/forward_ctrl.sv
src/fpga_core.sv
bench/tb_fpga_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the forwarder testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fpga_core -f all.f \
  --Mdir obj_dir -o sim_tb_fpga_core
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_tb_fpga_core
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulation failed with status $sim_status"
  exit 1
fi

echo "Simulation completed"
exit 0

//--- bench/tb_fpga_core.sv
/* Forwarder core testbench */

`timescale 1ns/1ns
`default_nettype none

module tb_fpga_core;

  localparam integer timeout_cycles = 40 * 500;  // 40 frames, 70 words plus gaps each.
  localparam integer exp_depth      = 16384;     // Scoreboard bytes per port.
  localparam logic [63:0] start_word = {core_pkg::sfd_byte, {6{core_pkg::preamble_byte}},
                                        core_pkg::xgmii_start};

  logic        clk;
  logic        reset;
  logic [63:0] rxd [2];  // Index 0 is port 1.
  logic [7:0]  rxc [2];
  logic [63:0] txd [2];
  logic [7:0]  txc [2];
  logic [1:0]  sfp_led [2];
  logic [1:0]  sma_led;

  // Expected frames, indexed by output port.
  logic [7:0]  exp_data [2][exp_depth];
  integer      exp_len [2][64];
  integer      data_head [2];
  integer      data_tail [2];
  integer      len_head [2];
  integer      len_tail [2];

  // Output monitor state.
  logic [7:0]  got [2][1024];
  integer      got_cnt [2];
  logic [1:0]  mon_in;     // Inside a frame on txd.
  logic [1:0]  frame_end;  // One-cycle mark at terminate.
  logic [1:0]  frame_ok;
  logic [1:0]  frame_err;
  logic [1:0]  led_prev;
  integer      toggles [2];
  integer      good_sent [2];
  logic        quiet;      // Before the first frame.
  integer      cycle_count = 0;

  fpga_core u_fpga_core (
    .clk(clk), .reset(reset),
    .sfp_1_rxd(rxd[0]), .sfp_1_rxc(rxc[0]), .sfp_2_rxd(rxd[1]), .sfp_2_rxc(rxc[1]),
    .sfp_1_txd(txd[0]), .sfp_1_txc(txc[0]), .sfp_2_txd(txd[1]), .sfp_2_txc(txc[1]),
    .sfp_1_led(sfp_led[0]), .sfp_2_led(sfp_led[1]), .sma_led(sma_led)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period.
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Run did not finish within %0d cycles", timeout_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic report_failure(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "check failed");
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  task automatic send_word(input integer p, input logic [63:0] d, input logic [7:0] c);
    @(negedge clk);
    rxd[p] = d;
    rxc[p] = c;
  endtask

  // Kind 0 good, 1 error char, 2 stray start char, 3 oversize.
  task automatic send_frame(input integer p, input integer len, input integer kind);
    logic [7:0]  pay [1024];
    logic [63:0] d;
    logic [7:0]  c;
    integer      bad_pos;
    integer      idx;
    bad_pos = $urandom % len;
    for (int j = 0; j < len; j++) begin
      pay[j] = 8'($urandom);
    end
    if (kind == 0) begin  // Expected on the opposite port.
      for (int j = 0; j < len; j++) begin
        exp_data[1-p][data_tail[1-p] + j] = pay[j];
      end
      data_tail[1-p] = data_tail[1-p] + len;
      exp_len[1-p][len_tail[1-p]] = len;
      len_tail[1-p] = len_tail[1-p] + 1;
      good_sent[p] = good_sent[p] + 1;
    end
    send_word(p, start_word, 8'h01);
    for (int w = 0; w <= len / 8; w++) begin
      for (int i = 0; i < 8; i++) begin
        idx = 8 * w + i;
        c[i] = 1'b1;
        if (idx > len) d[8*i +: 8] = core_pkg::xgmii_idle;
        else if (idx == len) d[8*i +: 8] = core_pkg::xgmii_term;
        else if (idx == bad_pos && kind == 1) d[8*i +: 8] = core_pkg::xgmii_error;
        else if (idx == bad_pos && kind == 2) d[8*i +: 8] = core_pkg::xgmii_start;
        else begin
          d[8*i +: 8] = pay[idx];
          c[i]        = 1'b0;
        end
      end
      send_word(p, d, c);
    end
    repeat (12 + $urandom % 8) send_word(p, core_pkg::idle_word, 8'hFF);  // Gap.
  endtask

  task automatic run_port(input integer p);
    integer len;
    for (int k = 0; k < 14; k++) begin
      case (k)
        0: len = 1;
        1: len = 8;  // Terminate alone in lane 0.
        2: len = 500;
        default: len = 1 + $urandom % 500;
      endcase
      send_frame(p, len, 0);
    end
    assert (sfp_led[p][1] == 1'b0) else report_failure("drop flag set before any bad frame");
    send_frame(p, 16 + $urandom % 100, 1 + p);  // Each port sees a different bad kind first.
    assert (sfp_led[p][1] == 1'b1) else report_failure("drop flag clear after bad frame");
    send_frame(p, 16 + $urandom % 100, 2 - p);
    send_frame(p, 520 + $urandom % 80, 3);  // Longer than the buffer.
    for (int k = 0; k < 3; k++) begin
      send_frame(p, 1 + $urandom % 500, 0);
    end
  endtask

  // ==========================================================================
  // Output monitor
  // ==========================================================================
  always @(negedge clk) begin : monitor
    logic       ended;
    logic       ok;
    logic [7:0] lane;
    frame_end = 2'b00;
    frame_err = 2'b00;
    if (!reset) begin
      for (int q = 0; q < 2; q++) begin
        if (sfp_led[q][0] != led_prev[q]) toggles[q] = toggles[q] + 1;
        led_prev[q] = sfp_led[q][0];
        if (!mon_in[q]) begin
          if (txc[q] == 8'h01 && txd[q] == start_word) begin
            mon_in[q]  = 1'b1;
            got_cnt[q] = 0;
          end else if (txc[q] != 8'hFF || txd[q] != core_pkg::idle_word) begin
            frame_err[q] = 1'b1;  // Garbage between frames.
          end
        end else begin
          ended = 1'b0;
          for (int i = 0; i < 8; i++) begin
            lane = txd[q][8*i +: 8];
            if (ended) begin
              if (!txc[q][i] || lane != core_pkg::xgmii_idle) frame_err[q] = 1'b1;
            end else if (!txc[q][i] && got_cnt[q] < 1024) begin
              got[q][got_cnt[q]] = lane;
              got_cnt[q] = got_cnt[q] + 1;
            end else if (txc[q][i] && lane == core_pkg::xgmii_term) begin
              ended = 1'b1;
            end else begin
              frame_err[q] = 1'b1;  // Stray control inside the frame.
            end
          end
          if (ended) begin
            ok = (len_head[q] < len_tail[q]) && (exp_len[q][len_head[q]] == got_cnt[q]);
            for (int j = 0; j < got_cnt[q]; j++) begin
              if (ok && exp_data[q][data_head[q] + j] != got[q][j]) ok = 1'b0;
            end
            if (len_head[q] < len_tail[q]) begin  // Pop the head frame.
              data_head[q] = data_head[q] + exp_len[q][len_head[q]];
              len_head[q]  = len_head[q] + 1;
            end
            frame_ok[q]  = ok;
            frame_end[q] = 1'b1;
            mon_in[q]    = 1'b0;
          end
        end
      end
    end
  end

  a_data_1 : assert property (@(posedge clk) disable iff (reset) frame_end[0] |-> frame_ok[0])
    else report_failure("port 1 frame bytes or length differ from expected");
  a_data_2 : assert property (@(posedge clk) disable iff (reset) frame_end[1] |-> frame_ok[1])
    else report_failure("port 2 frame bytes or length differ from expected");
  a_framing_1 : assert property (@(posedge clk) disable iff (reset) !frame_err[0])
    else report_failure("port 1 txd breaks the XGMII framing rule");
  a_framing_2 : assert property (@(posedge clk) disable iff (reset) !frame_err[1])
    else report_failure("port 2 txd breaks the XGMII framing rule");
  a_busy_1 : assert property (@(posedge clk) disable iff (reset) mon_in[0] |-> sma_led[1])
    else report_failure("sma_led[1] low while port 1 transmits");
  a_busy_2 : assert property (@(posedge clk) disable iff (reset) mon_in[1] |-> sma_led[0])
    else report_failure("sma_led[0] low while port 2 transmits");
  a_quiet : assert property (@(posedge clk) disable iff (reset)
    quiet |-> txd[0] == core_pkg::idle_word && txc[0] == 8'hFF && txd[1] == core_pkg::idle_word
      && txc[1] == 8'hFF && sfp_led[0] == 2'b00 && sfp_led[1] == 2'b00 && sma_led == 2'b00)
    else report_failure("outputs not idle after reset");

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    void'($urandom(91));
    reset    = 1'b1;
    quiet    = 1'b1;
    mon_in   = 2'b00;
    led_prev = 2'b00;
    for (int q = 0; q < 2; q++) begin
      rxd[q] = core_pkg::idle_word;
      rxc[q] = 8'hFF;
      {data_head[q], data_tail[q], len_head[q], len_tail[q]} = '0;
      {got_cnt[q], toggles[q], good_sent[q]} = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    assert (u_fpga_core.u_ctrl.state[0] == core_pkg::st_idle &&
            u_fpga_core.u_ctrl.state[1] == core_pkg::st_idle)
      else report_failure("forwarding FSM not idle after reset");
    repeat (20) @(negedge clk);
    quiet = 1'b0;
    fork
      run_port(0);
      run_port(1);
    join
    while (len_head[0] != len_tail[0] || len_head[1] != len_tail[1] || mon_in != 2'b00) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
    for (int q = 0; q < 2; q++) begin
      assert (toggles[q] == good_sent[q]) else report_failure("activity LED toggle count wrong");
      assert (sfp_led[q][1] == 1'b1) else report_failure("drop flag not sticky");
      assert (data_head[q] == data_tail[q]) else report_failure("expected bytes left over");
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/fpga_core.sv
/* Two-port XGMII forwarder core */

`timescale 1ns/1ns
`default_nettype none

module fpga_core (
  input  wire logic        clk,        // Core clock, all ports.
  input  wire logic        reset,
  input  wire logic [63:0] sfp_1_rxd,
  input  wire logic [7:0]  sfp_1_rxc,
  input  wire logic [63:0] sfp_2_rxd,
  input  wire logic [7:0]  sfp_2_rxc,
  output logic [63:0]      sfp_1_txd,
  output logic [7:0]       sfp_1_txc,
  output logic [63:0]      sfp_2_txd,
  output logic [7:0]       sfp_2_txc,
  output logic [1:0]       sfp_1_led,
  output logic [1:0]       sfp_2_led,
  output logic [1:0]       sma_led
);

  // Parser to buffer.
  logic                        wr_valid_1, wr_last_1, wr_bad_1;
  logic                        wr_valid_2, wr_last_2, wr_bad_2;
  logic [63:0]                 wr_data_1, wr_data_2;
  logic [core_pkg::keep_w-1:0] wr_bytes_1, wr_bytes_2;

  // Buffer to framer.
  logic                        rd_en_12, rd_last_12, rd_en_21, rd_last_21;
  logic [63:0]                 rd_data_12, rd_data_21;
  logic [core_pkg::keep_w-1:0] rd_bytes_12, rd_bytes_21;

  // Controller links.
  logic [core_pkg::fifo_aw:0]  frame_count_12, frame_count_21;
  logic                        drop_1, drop_2;
  logic                        tx_start_12, tx_start_21, tx_done_12, tx_done_21;

  // ==========================================================================
  // Port 1 to port 2
  // ==========================================================================
  xgmii_rx_parser u_rx_1 (
    .clk(clk), .reset(reset), .rxd(sfp_1_rxd), .rxc(sfp_1_rxc),
    .wr_valid(wr_valid_1), .wr_data(wr_data_1), .wr_bytes(wr_bytes_1),
    .wr_last(wr_last_1), .wr_bad(wr_bad_1)
  );

  frame_fifo u_fifo_12 (
    .clk(clk), .reset(reset),
    .wr_valid(wr_valid_1), .wr_data(wr_data_1), .wr_bytes(wr_bytes_1),
    .wr_last(wr_last_1), .wr_bad(wr_bad_1),
    .rd_en(rd_en_12), .rd_data(rd_data_12), .rd_bytes(rd_bytes_12),
    .rd_last(rd_last_12), .frame_count(frame_count_12), .drop(drop_1)
  );

  xgmii_tx_framer u_tx_2 (
    .clk(clk), .reset(reset), .tx_start(tx_start_12),
    .rd_data(rd_data_12), .rd_bytes(rd_bytes_12), .rd_last(rd_last_12),
    .rd_en(rd_en_12), .tx_done(tx_done_12), .txd(sfp_2_txd), .txc(sfp_2_txc)
  );

  // ==========================================================================
  // Port 2 to port 1
  // ==========================================================================
  xgmii_rx_parser u_rx_2 (
    .clk(clk), .reset(reset), .rxd(sfp_2_rxd), .rxc(sfp_2_rxc),
    .wr_valid(wr_valid_2), .wr_data(wr_data_2), .wr_bytes(wr_bytes_2),
    .wr_last(wr_last_2), .wr_bad(wr_bad_2)
  );

  frame_fifo u_fifo_21 (
    .clk(clk), .reset(reset),
    .wr_valid(wr_valid_2), .wr_data(wr_data_2), .wr_bytes(wr_bytes_2),
    .wr_last(wr_last_2), .wr_bad(wr_bad_2),
    .rd_en(rd_en_21), .rd_data(rd_data_21), .rd_bytes(rd_bytes_21),
    .rd_last(rd_last_21), .frame_count(frame_count_21), .drop(drop_2)
  );

  xgmii_tx_framer u_tx_1 (
    .clk(clk), .reset(reset), .tx_start(tx_start_21),
    .rd_data(rd_data_21), .rd_bytes(rd_bytes_21), .rd_last(rd_last_21),
    .rd_en(rd_en_21), .tx_done(tx_done_21), .txd(sfp_1_txd), .txc(sfp_1_txc)
  );

  // Scheduling and LEDs.
  forward_ctrl u_ctrl (
    .clk(clk), .reset(reset),
    .frame_count_12(frame_count_12), .frame_count_21(frame_count_21),
    .drop_1(drop_1), .drop_2(drop_2),
    .tx_done_12(tx_done_12), .tx_done_21(tx_done_21),
    .tx_start_12(tx_start_12), .tx_start_21(tx_start_21),
    .sfp_1_led(sfp_1_led), .sfp_2_led(sfp_2_led), .sma_led(sma_led)
  );

endmodule

`default_nettype wire

//--- src/forward_ctrl.sv
/* Two-direction forwarding controller */

`timescale 1ns/1ns
`default_nettype none

module forward_ctrl (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic [core_pkg::fifo_aw:0] frame_count_12,
  input  wire logic [core_pkg::fifo_aw:0] frame_count_21,
  input  wire logic                       drop_1,
  input  wire logic                       drop_2,
  input  wire logic                       tx_done_12,
  input  wire logic                       tx_done_21,
  output logic                            tx_start_12,
  output logic                            tx_start_21,
  output logic [1:0]                      sfp_1_led,
  output logic [1:0]                      sfp_2_led,
  output logic [1:0]                      sma_led
);

  // Index 0 is port 1 to port 2, index 1 is port 2 to port 1.
  core_pkg::fwd_state_t state [2];

  logic [1:0] pending;    // Committed frame waiting.
  logic [1:0] done;
  logic [1:0] start;
  logic [1:0] rx_toggle;  // Flips per forwarded frame.
  logic [1:0] drop_flag;  // Sticky drop per input port.

  assign pending = {frame_count_21 != '0, frame_count_12 != '0};
  assign done    = {tx_done_21, tx_done_12};

  // ==========================================================================
  // Direction FSMs
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int d = 0; d < 2; d++) begin
        state[d] <= core_pkg::st_idle;
      end
      start     <= '0;
      rx_toggle <= '0;
      drop_flag <= '0;
    end else begin
      for (int d = 0; d < 2; d++) begin
        start[d] <= 1'b0;
        case (state[d])
          core_pkg::st_idle: begin
            if (pending[d]) begin
              start[d]     <= 1'b1;  // Framer begins next cycle.
              rx_toggle[d] <= !rx_toggle[d];
              state[d]     <= core_pkg::st_start;
            end
          end
          core_pkg::st_start: state[d] <= core_pkg::st_busy;
          core_pkg::st_busy: begin
            if (done[d]) begin
              state[d] <= core_pkg::st_idle;
            end
          end
          default: state[d] <= core_pkg::st_idle;
        endcase
      end
      drop_flag <= drop_flag | {drop_2, drop_1};
    end
  end

  assign tx_start_12 = start[0];
  assign tx_start_21 = start[1];

  // LEDs.
  assign sfp_1_led = {drop_flag[0], rx_toggle[0]};
  assign sfp_2_led = {drop_flag[1], rx_toggle[1]};
  assign sma_led   = {state[1] != core_pkg::st_idle, state[0] != core_pkg::st_idle};

  // Start pulse only with a committed frame still in the buffer.
  a_start_pending : assert property (@(posedge clk) disable iff (reset)
    tx_start_12 |-> frame_count_12 != '0);

endmodule

`default_nettype wire

//--- src/xgmii_tx_framer.sv
/* XGMII transmit framer */

`timescale 1ns/1ns
`default_nettype none

module xgmii_tx_framer (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         tx_start,
  input  wire logic [63:0]                  rd_data,
  input  wire logic [core_pkg::keep_w-1:0]  rd_bytes,
  input  wire logic                         rd_last,
  output logic                              rd_en,
  output logic                              tx_done,
  output logic [63:0]                       txd,
  output logic [7:0]                        txc
);

  typedef enum logic [1:0] {
    fr_idle,  // Idle fill.
    fr_data,  // Payload words.
    fr_term,  // Stand-alone terminate word.
    fr_gap    // Trailing idle word.
  } fr_state_t;

  fr_state_t   state;
  logic [63:0] tail_d;  // Head word with terminate and idle fill.
  logic [7:0]  tail_c;

  assign rd_en = (state == fr_data);  // One word per cycle.

  // ==========================================================================
  // Lane placement of terminate after the final byte
  // ==========================================================================
  always_comb begin
    tail_d = '0;
    tail_c = '0;
    for (int i = 0; i < 8; i++) begin
      if (i[core_pkg::keep_w-1:0] < rd_bytes) begin
        tail_d[8*i +: 8] = rd_data[8*i +: 8];
        tail_c[i]        = 1'b0;
      end else if (i[core_pkg::keep_w-1:0] == rd_bytes) begin
        tail_d[8*i +: 8] = core_pkg::xgmii_term;
        tail_c[i]        = 1'b1;
      end else begin
        tail_d[8*i +: 8] = core_pkg::xgmii_idle;
        tail_c[i]        = 1'b1;
      end
    end
  end

  // ==========================================================================
  // Sequencer
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= fr_idle;
      txd     <= core_pkg::idle_word;
      txc     <= 8'hFF;
      tx_done <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      case (state)
        fr_idle: begin
          txd <= core_pkg::idle_word;
          txc <= 8'hFF;
          if (tx_start) begin  // Start, six preamble bytes, SFD.
            txd   <= {core_pkg::sfd_byte, {6{core_pkg::preamble_byte}},
                      core_pkg::xgmii_start};
            txc   <= 8'h01;
            state <= fr_data;
          end
        end
        fr_data: begin
          txd <= tail_d;  // Plain data unless last and partial.
          txc <= tail_c;
          if (rd_last) begin
            state <= (rd_bytes == 4'd8) ? fr_term : fr_gap;
          end
        end
        fr_term: begin
          txd   <= {{7{core_pkg::xgmii_idle}}, core_pkg::xgmii_term};
          txc   <= 8'hFF;
          state <= fr_gap;
        end
        fr_gap: begin
          txd     <= core_pkg::idle_word;
          txc     <= 8'hFF;
          tx_done <= 1'b1;
          state   <= fr_idle;
        end
        default: state <= fr_idle;
      endcase
    end
  end

  // The controller must wait for tx_done.
  a_no_overlap : assert property (@(posedge clk) disable iff (reset)
    tx_start |-> state == fr_idle);

endmodule

`default_nettype wire

//--- src/frame_fifo.sv
/* Store-and-forward frame buffer */

`timescale 1ns/1ns
`default_nettype none

module frame_fifo (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         wr_valid,
  input  wire logic [63:0]                  wr_data,
  input  wire logic [core_pkg::keep_w-1:0]  wr_bytes,
  input  wire logic                         wr_last,
  input  wire logic                         wr_bad,
  input  wire logic                         rd_en,
  output logic [63:0]                       rd_data,
  output logic [core_pkg::keep_w-1:0]       rd_bytes,
  output logic                              rd_last,
  output logic [core_pkg::fifo_aw:0]        frame_count,
  output logic                              drop
);

  localparam integer aw = core_pkg::fifo_aw;

  logic [64+core_pkg::keep_w:0] mem [core_pkg::fifo_depth];  // {last, bytes, data}.

  logic [aw:0] wr_ptr;      // Speculative write position.
  logic [aw:0] commit_ptr;  // End of last good frame.
  logic [aw:0] rd_ptr;
  logic        discarding;  // Skipping rest of an overflowed frame.

  logic full;
  logic do_write;
  logic overflow;
  logic commit;
  logic rewind;

  // ==========================================================================
  // Write side
  // ==========================================================================
  assign full     = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
  assign overflow = wr_valid && !discarding && full;
  assign do_write = wr_valid && !discarding && !full;
  assign commit   = do_write && wr_last && !wr_bad;
  assign rewind   = overflow || (do_write && wr_last && wr_bad);

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr[aw-1:0]] <= {wr_last, wr_bytes, wr_data};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr      <= '0;
      commit_ptr  <= '0;
      rd_ptr      <= '0;
      discarding  <= 1'b0;
      frame_count <= '0;
      drop        <= 1'b0;
    end else begin
      drop <= rewind;  // One pulse per lost frame.
      if (rewind) begin
        wr_ptr <= commit_ptr;  // Roll back the partial frame.
      end else if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (commit) begin
        commit_ptr <= wr_ptr + 1'b1;
      end
      if (overflow) begin
        discarding <= !wr_last;
      end else if (discarding && wr_valid && wr_last) begin
        discarding <= 1'b0;  // Next word opens a new frame.
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({commit, rd_en && rd_last})
        2'b10:   frame_count <= frame_count + 1'b1;
        2'b01:   frame_count <= frame_count - 1'b1;
        default: frame_count <= frame_count;
      endcase
    end
  end

  // ==========================================================================
  // Read side, first word falls through
  // ==========================================================================
  assign {rd_last, rd_bytes, rd_data} = mem[rd_ptr[aw-1:0]];

  a_rd_committed : assert property (@(posedge clk) disable iff (reset)
    rd_en |-> frame_count != '0);

  a_count_range : assert property (@(posedge clk) disable iff (reset)
    frame_count <= core_pkg::fifo_depth);

endmodule

`default_nettype wire

//--- src/xgmii_rx_parser.sv
/* XGMII receive parser */

`timescale 1ns/1ns
`default_nettype none

module xgmii_rx_parser (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic [63:0]                 rxd,
  input  wire logic [7:0]                  rxc,
  output logic                             wr_valid,
  output logic [63:0]                      wr_data,
  output logic [core_pkg::keep_w-1:0]      wr_bytes,
  output logic                             wr_last,
  output logic                             wr_bad
);

  logic                        in_frame;    // Between start and terminate.
  logic                        hold_valid;  // Holding register occupied.
  logic                        hold_last;   // Held word closes the frame.
  logic [63:0]                 hold_data;
  logic [core_pkg::keep_w-1:0] hold_bytes;
  logic                        bad;         // Sticky error for this frame.

  logic                        term_hit;
  logic [core_pkg::keep_w-1:0] term_lane;
  logic                        ctrl_bad;    // Control char ahead of terminate.

  // ==========================================================================
  // Lane decode
  // ==========================================================================
  always_comb begin
    term_hit  = 1'b0;
    term_lane = '0;
    ctrl_bad  = 1'b0;
    for (int i = 7; i >= 0; i--) begin  // Lowest terminate lane wins.
      if (rxc[i] && rxd[8*i +: 8] == core_pkg::xgmii_term) begin
        term_hit  = 1'b1;
        term_lane = i[core_pkg::keep_w-1:0];
      end
    end
    for (int i = 0; i < 8; i++) begin
      if (rxc[i] && (!term_hit || i[core_pkg::keep_w-1:0] < term_lane)) begin
        ctrl_bad = 1'b1;  // Error or stray control inside the frame.
      end
    end
  end

  // ==========================================================================
  // Frame tracking, one word held back
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      in_frame   <= 1'b0;
      hold_valid <= 1'b0;
      hold_last  <= 1'b0;
      bad        <= 1'b0;
      wr_valid   <= 1'b0;
      wr_last    <= 1'b0;
      wr_bad     <= 1'b0;
    end else begin
      wr_valid <= 1'b0;
      wr_last  <= 1'b0;
      wr_bad   <= 1'b0;
      if (hold_valid && hold_last) begin  // Partial closing word.
        wr_valid   <= 1'b1;
        wr_last    <= 1'b1;
        wr_bad     <= bad;
        hold_valid <= 1'b0;
      end
      if (!in_frame) begin
        if (rxc[0] && rxd[7:0] == core_pkg::xgmii_start) begin
          in_frame <= 1'b1;  // Preamble word itself is dropped.
          bad      <= 1'b0;
        end
      end else begin
        wr_valid <= hold_valid;  // Release previous word.
        if (term_hit) begin
          in_frame <= 1'b0;
          if (term_lane == '0) begin  // Held word is the last one.
            wr_last    <= 1'b1;
            wr_bad     <= bad | ctrl_bad;
            hold_valid <= 1'b0;
          end else begin
            hold_valid <= 1'b1;
            hold_last  <= 1'b1;
            bad        <= bad | ctrl_bad;
          end
        end else begin
          hold_valid <= 1'b1;
          hold_last  <= 1'b0;
          bad        <= bad | ctrl_bad;
        end
      end
    end
  end

  // Payload path.
  always_ff @(posedge clk) begin
    if (hold_valid) begin
      wr_data  <= hold_data;
      wr_bytes <= hold_bytes;
    end
    if (in_frame) begin
      hold_data  <= rxd;
      hold_bytes <= term_hit ? term_lane : 4'd8;
    end
  end

  // Only a closing word may be partial.
  a_full_words : assert property (@(posedge clk) disable iff (reset)
    wr_valid && !wr_last |-> wr_bytes == 4'd8);

endmodule

`default_nettype wire

//--- src/core_pkg.sv
/* Forwarder shared constants and types */

`default_nettype none

package core_pkg;

  // ==========================================================================
  // XGMII control characters and framing bytes
  // ==========================================================================
  localparam logic [7:0] xgmii_idle  = 8'h07;  // Inter-frame fill.
  localparam logic [7:0] xgmii_start = 8'hFB;  // Start, lane 0 only.
  localparam logic [7:0] xgmii_term  = 8'hFD;  // Terminate.
  localparam logic [7:0] xgmii_error = 8'hFE;  // Error propagation.

  localparam logic [7:0] preamble_byte = 8'h55;  // Preamble fill.
  localparam logic [7:0] sfd_byte      = 8'hD5;  // Start frame delimiter.

  // Full idle word, sent with txc all ones.
  localparam logic [63:0] idle_word = {8{xgmii_idle}};

  // ==========================================================================
  // Frame buffer geometry
  // ==========================================================================
  localparam integer fifo_depth = 64;  // Payload words per buffer.
  localparam integer fifo_aw    = 6;   // Log2 of depth.
  localparam integer keep_w     = 4;   // Byte count, 1 to 8.

  // Per-direction forwarding FSM.
  typedef enum logic [1:0] {
    st_idle,   // Waiting for a committed frame.
    st_start,  // Start pulse just issued.
    st_busy    // Framer transmitting.
  } fwd_state_t;

endpackage

`default_nettype wire
